//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - .
    files:
      - dcache_pkg.sv
      - dcache_array.sv
      - dcache_line_bridge.sv
      - dcache_ctrl.sv
      - dcache_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - dcache_props.sv
      - tb_dcache.sv

//--- dcache_array.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_array
    import dcache_pkg::*;
#(
    parameter type entry_t = line_t
) (
    input  logic                   clk,
    input  logic [`DC_INDEX_W-1:0] index,
    input  logic                   wen,
    input  entry_t                 wdata,
    output entry_t                 rdata
);

    // one entry per set
    entry_t mem_q [0:`DC_SETS-1];

    // single port, read-before-write
    always_ff @(posedge clk) begin
        if (wen) begin
            mem_q[index] <= wdata;
        end
        rdata <= mem_q[index];      // old entry on a same-index write
    end

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,

    // processor side
    input  logic                   req_valid,
    input  logic                   req_write,
    input  logic [`DC_ADDR_W-1:0]  req_addr,
    input  logic [`DC_WORD_W-1:0]  req_wdata,
    output logic                   req_ready,
    output logic                   resp_valid,
    output logic [`DC_WORD_W-1:0]  resp_rdata,

    // tag and line arrays
    output logic [`DC_INDEX_W-1:0] tag_index,
    output logic                   tag_wen,
    output tag_entry_t             tag_wdata,
    input  tag_entry_t             tag_rdata,
    output logic [`DC_INDEX_W-1:0] line_index,
    output logic                   line_wen,
    output line_t                  line_wdata,
    input  line_t                  line_rdata,

    // line bridge
    output logic                   op_valid,
    output mem_op_e                op_code,
    output logic [`DC_ADDR_W-1:0]  op_addr,
    output line_t                  op_wline,
    output logic [`DC_WORD_W-1:0]  op_wword,
    input  logic                   op_ready,
    input  logic                   op_done,
    input  line_t                  op_rline
);

    localparam int WORD_W  = `DC_WORD_W;
    localparam int INDEX_W = `DC_INDEX_W;
    localparam int TAG_W   = `DC_TAG_W;
    localparam int BYTE_W  = $clog2(`DC_WORD_W / 8);
    localparam int WSEL_W  = $clog2(`DC_LINE_WORDS);
    localparam int OFF_W   = BYTE_W + WSEL_W;

    typedef enum logic [3:0] {
        st_init,            // clearing valid bits after reset
        st_idle,
        st_lookup,          // array data back, compare
        st_store_hit,
        st_evict_req,
        st_evict_wait,
        st_refill_req,
        st_refill_wait,
        st_word_req,
        st_word_wait
    } state_e;

    state_e               state;
    logic [INDEX_W-1:0]   init_cnt;

    // accepted request
    logic [`DC_ADDR_W-1:0] addr_q;
    logic [WORD_W-1:0]    wdata_q;
    logic                 write_q;

    logic [INDEX_W-1:0]   req_index;
    logic [INDEX_W-1:0]   addr_index;
    logic [TAG_W-1:0]     addr_tag;
    logic [WSEL_W-1:0]    addr_wsel;
    logic [INDEX_W-1:0]   set_index;
    logic                 hit;
    line_t                merged;

    assign req_index  = req_addr[OFF_W +: INDEX_W];
    assign addr_index = addr_q[OFF_W +: INDEX_W];
    assign addr_tag   = addr_q[`DC_ADDR_W-1 -: TAG_W];
    assign addr_wsel  = addr_q[BYTE_W +: WSEL_W];

    assign hit = tag_rdata.valid && (tag_rdata.tag == addr_tag);

    // ======================================================================
    // control FSM
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_init;
            init_cnt   <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            case (state)
                st_init: begin
                    init_cnt <= init_cnt + 1'b1;
                    if (init_cnt == INDEX_W'(`DC_SETS - 1)) state <= st_idle;
                end
                st_idle: if (req_valid) state <= st_lookup;
                st_lookup: begin
                    if (hit && !write_q) begin
                        resp_valid <= 1'b1;         // load hit, 2 cycles after accept
                        state      <= st_idle;
                    end else if (hit) begin
                        state <= st_store_hit;
                    end else if (write_q) begin
                        state <= st_word_req;       // no write allocate
                    end else if (tag_rdata.valid && tag_rdata.dirty) begin
                        state <= st_evict_req;
                    end else begin
                        state <= st_refill_req;
                    end
                end
                st_store_hit:   state <= st_idle;
                st_evict_req:   if (op_ready) state <= st_evict_wait;
                st_evict_wait:  if (op_done)  state <= st_refill_req;
                st_refill_req:  if (op_ready) state <= st_refill_wait;
                st_refill_wait: begin
                    if (op_done) begin
                        resp_valid <= 1'b1;
                        state      <= st_idle;
                    end
                end
                st_word_req:    if (op_ready) state <= st_word_wait;
                st_word_wait:   if (op_done)  state <= st_idle;
                default:        state <= st_idle;
            endcase
        end
    end

    // request latch and load data
    always_ff @(posedge clk) begin
        if (state == st_idle && req_valid) begin
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            write_q <= req_write;
        end
        if (state == st_lookup) begin
            resp_rdata <= line_rdata[addr_wsel*WORD_W +: WORD_W];
        end else if (state == st_refill_wait && op_done) begin
            resp_rdata <= op_rline[addr_wsel*WORD_W +: WORD_W];
        end
    end

    assign req_ready = (state == st_idle);

    // ======================================================================
    // array access
    // ======================================================================

    // in idle the arrays are read with the incoming address
    assign set_index  = (state == st_init) ? init_cnt :
                        (state == st_idle) ? req_index : addr_index;
    assign tag_index  = set_index;
    assign line_index = set_index;

    always_comb begin
        merged = line_rdata;
        merged[addr_wsel*WORD_W +: WORD_W] = wdata_q;
    end

    always_comb begin
        tag_wen    = 1'b0;
        tag_wdata  = '0;                    // invalid entry during the reset walk
        line_wen   = 1'b0;
        line_wdata = op_rline;
        case (state)
            st_init: tag_wen = 1'b1;
            st_store_hit: begin
                tag_wen    = 1'b1;
                tag_wdata  = '{valid: 1'b1, dirty: 1'b1, tag: addr_tag};
                line_wen   = 1'b1;
                line_wdata = merged;
            end
            st_refill_wait: begin
                tag_wen   = op_done;            // install clean line
                tag_wdata = '{valid: 1'b1, dirty: 1'b0, tag: addr_tag};
                line_wen  = op_done;
            end
            default: ;
        endcase
    end

    // operation to the line bridge
    assign op_valid = (state == st_evict_req) || (state == st_refill_req) ||
                      (state == st_word_req);

    always_comb begin
        case (state)
            st_evict_req: begin
                op_code = op_line_write;
                op_addr = {tag_rdata.tag, addr_index, {OFF_W{1'b0}}};   // victim line
            end
            st_refill_req: begin
                op_code = op_line_read;
                op_addr = addr_q;
            end
            default: begin
                op_code = op_word_write;
                op_addr = addr_q;
            end
        endcase
    end

    assign op_wline = line_rdata;   // victim data, held while the set index holds
    assign op_wword = wdata_q;

endmodule

//--- dcache_line_bridge.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_line_bridge
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    // controller side
    input  logic                  op_valid,
    input  mem_op_e               op_code,
    input  logic [`DC_ADDR_W-1:0] op_addr,
    input  line_t                 op_wline,
    input  logic [`DC_WORD_W-1:0] op_wword,
    output logic                  op_ready,
    output logic                  op_done,
    output line_t                 op_rline,

    // word-wide memory port
    output logic [`DC_ADDR_W-1:0] mem_addr,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic [`DC_WORD_W-1:0] mem_wdata,
    input  logic [`DC_WORD_W-1:0] mem_rdata,
    input  logic                  mem_valid
);

    localparam int ADDR_W = `DC_ADDR_W;
    localparam int WORD_W = `DC_WORD_W;
    localparam int BEAT_W = $clog2(`DC_LINE_WORDS);
    localparam int OFF_W  = BEAT_W + $clog2(`DC_WORD_W / 8);   // byte offset in a line

    typedef enum logic [1:0] {
        st_idle,
        st_line_read,
        st_line_write,
        st_word_write
    } state_e;

    state_e              state;
    logic [BEAT_W-1:0]   beat;          // advances on acknowledge only
    logic                last_beat;
    logic                accept;

    logic [ADDR_W-1:0]   addr_q;        // line base, or word address
    line_t               wline_q;
    logic [WORD_W-1:0]   wword_q;
    line_t               rline_q;

    assign accept    = (state == st_idle) && op_valid;
    assign last_beat = (state == st_word_write) || (beat == BEAT_W'(`DC_LINE_WORDS - 1));

    // ======================================================================
    // sequencing
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            beat    <= '0;
            op_done <= 1'b0;
        end else begin
            op_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (op_valid) begin
                        beat <= '0;
                        case (op_code)
                            op_line_read:  state <= st_line_read;
                            op_line_write: state <= st_line_write;
                            default:       state <= st_word_write;
                        endcase
                    end
                end
                default: begin
                    // a beat completes when memory acknowledges it
                    if (mem_valid) begin
                        if (last_beat) begin
                            state   <= st_idle;
                            beat    <= '0;
                            op_done <= 1'b1;
                        end else begin
                            beat <= beat + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // operation payload and read buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            if (op_code == op_word_write) begin
                addr_q <= op_addr;
            end else begin
                addr_q <= {op_addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
            end
            wline_q <= op_wline;
            wword_q <= op_wword;
        end
        if (state == st_line_read && mem_valid) begin
            rline_q[beat*WORD_W +: WORD_W] <= mem_rdata;    // slot of the acked beat
        end
    end

    // ======================================================================
    // memory command, decoded from registered state
    // ======================================================================

    assign mem_read  = (state == st_line_read);
    assign mem_write = (state == st_line_write) || (state == st_word_write);
    assign mem_addr  = addr_q + (ADDR_W'(beat) << 2);     // beat stays 0 on a word write
    assign mem_wdata = (state == st_word_write) ? wword_q
                                                : wline_q[beat*WORD_W +: WORD_W];

    assign op_ready = (state == st_idle);
    assign op_rline = rline_q;

endmodule

//--- dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// ======================================================================
// cache geometry
// ======================================================================

`define DC_ADDR_W      32                              // byte address
`define DC_WORD_W      32
`define DC_LINE_WORDS  8
`define DC_LINE_W      (`DC_WORD_W * `DC_LINE_WORDS)   // 256 bits

`define DC_SETS        16                              // direct mapped
`define DC_INDEX_W     4

// address bits above index and line offset
`define DC_TAG_W       23

`endif

//--- dcache_pkg.sv
package dcache_pkg;

`include "dcache_params.svh"

    // line operations handed to the line bridge
    typedef enum logic [1:0] {
        op_line_read  = 2'd0,   // refill
        op_line_write = 2'd1,   // dirty eviction
        op_word_write = 2'd2    // store miss, no allocate
    } mem_op_e;

    // one entry of the tag store
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`DC_TAG_W-1:0] tag;
    } tag_entry_t;

    // word 0 sits in the low bits
    typedef logic [`DC_LINE_W-1:0] line_t;

endpackage

//--- dcache_props.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  req_valid,
    input logic                  req_ready,
    input logic                  req_write,
    input logic                  resp_valid,
    input logic [`DC_ADDR_W-1:0] mem_addr,
    input logic                  mem_read,
    input logic                  mem_write,
    input logic [`DC_WORD_W-1:0] mem_wdata,
    input logic                  mem_valid
);

    int   assert_errors = 0;
    logic load_pending;         // accepted load still unanswered

    always_ff @(posedge clk) begin
        if (reset) begin
            load_pending <= 1'b0;
        end else begin
            if (resp_valid) load_pending <= 1'b0;
            if (req_valid && req_ready && !req_write) load_pending <= 1'b1;  // new load wins
        end
    end

    a_cmd_excl: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write))
        else begin
            $error("mem_read and mem_write high together");
            assert_errors++;
        end

    // command held until acknowledged
    a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_read || mem_write) && !mem_valid |=>
            $stable(mem_addr) && $stable(mem_wdata) && $stable(mem_read) && $stable(mem_write))
        else begin
            $error("memory command changed before mem_valid");
            assert_errors++;
        end

    a_resp_load: assert property (@(posedge clk) disable iff (reset)
        resp_valid |-> load_pending)
        else begin
            $error("resp_valid without an accepted load");
            assert_errors++;
        end

    a_reset_idle: assert property (@(posedge clk)
        reset |=> !mem_read && !mem_write)
        else begin
            $error("memory command in the cycle after reset");
            assert_errors++;
        end

endmodule

bind dcache_top dcache_props u_dcache_props (
    .clk        (clk),
    .reset      (reset),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_write  (req_write),
    .resp_valid (resp_valid),
    .mem_addr   (mem_addr),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_wdata  (mem_wdata),
    .mem_valid  (mem_valid)
);

//--- dcache_top.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module dcache_top
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,

    // processor side
    input  logic                  req_valid,
    input  logic                  req_write,
    input  logic [`DC_ADDR_W-1:0] req_addr,
    input  logic [`DC_WORD_W-1:0] req_wdata,
    output logic                  req_ready,
    output logic                  resp_valid,
    output logic [`DC_WORD_W-1:0] resp_rdata,

    // memory side
    output logic [`DC_ADDR_W-1:0] mem_addr,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic [`DC_WORD_W-1:0] mem_wdata,
    input  logic [`DC_WORD_W-1:0] mem_rdata,
    input  logic                  mem_valid
);

    logic [`DC_INDEX_W-1:0] tag_index;
    logic                   tag_wen;
    tag_entry_t             tag_wdata;
    tag_entry_t             tag_rdata;
    logic [`DC_INDEX_W-1:0] line_index;
    logic                   line_wen;
    line_t                  line_wdata;
    line_t                  line_rdata;

    logic                   op_valid;
    mem_op_e                op_code;
    logic [`DC_ADDR_W-1:0]  op_addr;
    line_t                  op_wline;
    logic [`DC_WORD_W-1:0]  op_wword;
    logic                   op_ready;
    logic                   op_done;
    line_t                  op_rline;

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .tag_index  (tag_index),
        .tag_wen    (tag_wen),
        .tag_wdata  (tag_wdata),
        .tag_rdata  (tag_rdata),
        .line_index (line_index),
        .line_wen   (line_wen),
        .line_wdata (line_wdata),
        .line_rdata (line_rdata),
        .op_valid   (op_valid),
        .op_code    (op_code),
        .op_addr    (op_addr),
        .op_wline   (op_wline),
        .op_wword   (op_wword),
        .op_ready   (op_ready),
        .op_done    (op_done),
        .op_rline   (op_rline)
    );

    dcache_array #(.entry_t(tag_entry_t)) u_tag_array (
        .clk   (clk),
        .index (tag_index),
        .wen   (tag_wen),
        .wdata (tag_wdata),
        .rdata (tag_rdata)
    );

    dcache_array #(.entry_t(line_t)) u_line_array (
        .clk   (clk),
        .index (line_index),
        .wen   (line_wen),
        .wdata (line_wdata),
        .rdata (line_rdata)
    );

    dcache_line_bridge u_bridge (
        .clk       (clk),
        .reset     (reset),
        .op_valid  (op_valid),
        .op_code   (op_code),
        .op_addr   (op_addr),
        .op_wline  (op_wline),
        .op_wword  (op_wword),
        .op_ready  (op_ready),
        .op_done   (op_done),
        .op_rline  (op_rline),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_valid (mem_valid)
    );

endmodule

//--- sources.f
+incdir+.
dcache_pkg.sv
dcache_array.sv
dcache_line_bridge.sv
dcache_ctrl.sv
dcache_top.sv
dcache_props.sv
tb_dcache.sv

//--- tb_dcache.sv
`timescale 1ns/1ps

`include "dcache_params.svh"

module tb_dcache;

    localparam int          CLK_PERIOD      = 40;
    localparam int          N_REQ           = 500;
    localparam int          N_DIRECTED      = 5;
    localparam int          WIN_LINES       = 64;      // 4 lines compete for each set
    localparam int          WIN_WORDS       = WIN_LINES * `DC_LINE_WORDS;
    localparam logic [31:0] WIN_BASE        = 32'h8000_0000;
    localparam int          WATCHDOG_CYCLES = (N_REQ + N_DIRECTED + `DC_SETS) * 40 + 2 + `DC_SETS;

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    logic                  req_write;
    logic [`DC_ADDR_W-1:0] req_addr;
    logic [`DC_WORD_W-1:0] req_wdata;
    logic                  req_ready;
    logic                  resp_valid;
    logic [`DC_WORD_W-1:0] resp_rdata;
    logic [`DC_ADDR_W-1:0] mem_addr;
    logic                  mem_read;
    logic                  mem_write;
    logic [`DC_WORD_W-1:0] mem_wdata;
    logic [`DC_WORD_W-1:0] mem_rdata;
    logic                  mem_valid;

    logic [31:0] mem       [WIN_WORDS];     // memory behind the cache
    logic [31:0] ref_mem   [WIN_WORDS];     // architectural value of every word
    int          delay;                     // wait before the next acknowledge
    int          res_line  [`DC_SETS];      // resident line per set or -1 when empty
    logic        res_dirty [`DC_SETS];

    // beats seen on the memory port and beats expected
    logic [31:0] beat_addr[$];
    logic        beat_wr[$];
    logic [31:0] beat_data[$];
    logic [31:0] exp_addr[$];
    logic        exp_wr[$];
    logic [31:0] exp_data[$];

    int          errors;
    int          checks;

    dcache_top u_dcache_top (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .mem_addr   (mem_addr),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_valid  (mem_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // fill pattern that depends on every address bit
    function automatic logic [31:0] init_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    endfunction

    function automatic logic in_window(input logic [31:0] addr);
        return (addr >= WIN_BASE) && (addr < WIN_BASE + 4 * WIN_WORDS);
    endfunction

    // ======================================================================
    // memory model that acknowledges after 0 to 3 extra cycles
    // ======================================================================

    always @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
            delay     <= 0;
        end else if (mem_valid) begin
            // beat completes at this edge
            if (!in_window(mem_addr)) begin
                errors++;
                $display("memory beat outside the test window at %h", mem_addr);
            end else if (mem_write) begin
                mem[(mem_addr - WIN_BASE) >> 2] <= mem_wdata;
            end
            beat_addr.push_back(mem_addr);
            beat_wr.push_back(mem_write);
            beat_data.push_back(mem_wdata);
            mem_valid <= 1'b0;
            delay     <= $urandom_range(0, 3);
        end else if (mem_read || mem_write) begin
            if (delay == 0) begin
                mem_valid <= 1'b1;
                mem_rdata <= mem[(mem_addr - WIN_BASE) >> 2];
            end else begin
                delay <= delay - 1;
            end
        end
    end

    task automatic expect_beat(input logic [31:0] addr, input logic wr,
                               input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_wr.push_back(wr);
        exp_data.push_back(data);
    endtask

    task automatic check_beats();
        checks++;
        if (beat_addr.size() != exp_addr.size()) begin
            errors++;
            $display("wrong number of memory beats: %0d seen, %0d expected",
                     beat_addr.size(), exp_addr.size());
        end else begin
            foreach (exp_addr[i]) begin
                checks++;
                if (beat_addr[i] !== exp_addr[i] || beat_wr[i] !== exp_wr[i]) begin
                    errors++;
                    $display("Mismatch mem_addr/mem_write beat %0d: got %h/%h expected %h/%h",
                             i, beat_addr[i], beat_wr[i], exp_addr[i], exp_wr[i]);
                end else if (exp_wr[i] && beat_data[i] !== exp_data[i]) begin
                    errors++;
                    $display("Mismatch mem_wdata beat %0d at %h: got %h expected %h",
                             i, beat_addr[i], beat_data[i], exp_data[i]);
                end
            end
        end
    endtask

    // one processor request checked against the reference model
    task automatic do_request(input logic write, input logic [31:0] addr,
                              input logic [31:0] data);
        int   line_no;
        int   set;
        int   widx;
        int   victim;
        int   lat;
        logic hit;

        line_no = (addr - WIN_BASE) >> 5;
        set     = line_no % `DC_SETS;
        widx    = (addr - WIN_BASE) >> 2;
        victim  = res_line[set];
        hit     = (victim == line_no);

        exp_addr.delete();
        exp_wr.delete();
        exp_data.delete();
        if (write && !hit) begin
            expect_beat(addr, 1'b1, data);          // store miss without allocation
        end else if (!write && !hit) begin
            if (victim >= 0 && res_dirty[set]) begin
                for (int k = 0; k < `DC_LINE_WORDS; k++) begin
                    expect_beat(WIN_BASE + victim * 32 + k * 4, 1'b1,
                                ref_mem[victim * `DC_LINE_WORDS + k]);
                end
            end
            for (int k = 0; k < `DC_LINE_WORDS; k++) begin
                expect_beat(WIN_BASE + line_no * 32 + k * 4, 1'b0, '0);
            end
        end
        beat_addr.delete();
        beat_wr.delete();
        beat_data.delete();

        req_valid <= 1'b1;
        req_write <= write;
        req_addr  <= addr;
        req_wdata <= data;
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        req_valid <= 1'b0;

        // loads end at resp_valid and stores when req_ready returns
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (write ? !req_ready : !resp_valid);

        if (!write) begin
            checks++;
            if (resp_rdata !== ref_mem[widx]) begin
                errors++;
                $display("Mismatch resp_rdata at %h: got %h expected %h",
                         addr, resp_rdata, ref_mem[widx]);
            end
            if (hit && lat != 2) begin
                errors++;
                $display("load hit at %h answered after %0d cycles instead of 2", addr, lat);
            end
            if (!hit) begin
                res_line[set]  = line_no;
                res_dirty[set] = 1'b0;
            end
        end else begin
            ref_mem[widx] = data;
            if (hit) res_dirty[set] = 1'b1;
        end
        check_beats();
    endtask

    // ======================================================================
    // stimulus
    // ======================================================================

    initial begin
        int          line;
        logic [31:0] addr;

        void'($urandom(62));
        reset     = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        mem_valid = 1'b0;
        mem_rdata = '0;
        delay     = 0;
        errors    = 0;
        checks    = 0;
        line      = 0;
        for (int i = 0; i < WIN_WORDS; i++) begin
            mem[i]     = init_word(WIN_BASE + 4 * i);
            ref_mem[i] = mem[i];
        end
        foreach (res_line[s]) begin
            res_line[s]  = -1;
            res_dirty[s] = 1'b0;
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        for (int n = 0; n < N_REQ; n++) begin
            // a third of the requests stay on the previous line
            if (n == 0 || $urandom_range(0, 2) != 0) line = $urandom_range(0, WIN_LINES - 1);
            addr = WIN_BASE + line * 32 + $urandom_range(0, 7) * 4;
            do_request($urandom_range(0, 1), addr, $urandom);
        end

        // store then load on a resident line and on a line that is not resident
        addr = WIN_BASE + 5 * 32 + 12;
        do_request(1'b0, addr, '0);                 // line 5 resident
        do_request(1'b1, addr, $urandom);           // store hit
        do_request(1'b0, addr, '0);
        addr = addr + `DC_SETS * 32;                // line 21 in the same set
        do_request(1'b1, addr, $urandom);           // store miss
        do_request(1'b0, addr, '0);                 // evicts the dirty line 5

        // evict whatever is still resident so memory catches up
        for (int s = 0; s < `DC_SETS; s++) begin
            if (res_line[s] >= 0) begin
                do_request(1'b0, WIN_BASE + ((res_line[s] + `DC_SETS) % WIN_LINES) * 32, '0);
            end
        end

        for (int i = 0; i < WIN_WORDS; i++) begin
            checks++;
            if (mem[i] !== ref_mem[i]) begin
                errors++;
                $display("Mismatch mem[%h]: got %h expected %h",
                         WIN_BASE + 4 * i, mem[i], ref_mem[i]);
            end
        end

        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
                 u_dcache_top.u_dcache_props.assert_errors);
        if (errors == 0 && u_dcache_top.u_dcache_props.assert_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
